/* hdl/core_consts.svh */
// core width, register file size and reset vector defines
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// data path and address width, RV64
`define XLEN 64

// integer register file
`define REG_NUM 32                  // x0 .. x31
`define REG_AW 5                    // log2 of REG_NUM

// fetch address taken out of reset
`define RESET_PC 64'h8000_0000

// fixed 32-bit encoding, no compressed set
`define INST_W 32

`endif

/* hdl/isa_pkg.sv */
// RV64I instruction format structs, format union, opcode enum and funct constants
`default_nettype none

package isa_pkg;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;         // imm[11:0]
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // split immediate layout, read here as B-type
    typedef struct packed {
        logic [6:0] imm_hi;       // imm[12|10:5]
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;       // imm[4:1|11]
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic [19:0] imm;         // U: imm[31:12], J: scrambled imm[20:1]
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    // one instruction word, viewed per format once the opcode is known
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        u_fmt_t u;
    } inst_u;

    // branch funct3
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    localparam logic [2:0] F3_BLT = 3'b100;
    localparam logic [2:0] F3_BGE = 3'b101;

    // ALU funct3 for OP and OP-IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;    // SUB on OP

endpackage

`default_nettype wire

/* hdl/core_pkg.sv */
// data word, register address, control, execute and retire types passed between stages
`default_nettype none

package core_pkg;

`include "core_consts.svh"

    typedef logic [`XLEN-1:0]   xword_t;
    typedef logic [`REG_AW-1:0] reg_addr_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B                      // LUI
    } alu_op_e;

    typedef enum logic {SRC_A_RS1, SRC_A_PC}  src_a_e;
    typedef enum logic {SRC_B_RS2, SRC_B_IMM} src_b_e;
    typedef enum logic {WB_ALU, WB_PC4}       wb_sel_e;

    typedef enum logic [1:0] {
        PC_SEQ,
        PC_BRANCH,
        PC_JAL,
        PC_JALR
    } pc_sel_e;

    // decode output, consumed by execute and result
    typedef struct packed {
        alu_op_e    alu_op;
        src_a_e     src_a;
        src_b_e     src_b;
        wb_sel_e    wb_sel;
        pc_sel_e    pc_sel;
        logic [2:0] br_funct3;
        logic       reg_wen;
        reg_addr_t  rd;
        xword_t     imm;            // already sign extended
        logic       illegal;
    } ctrl_t;

    typedef struct packed {
        xword_t alu_res;
        logic   branch_taken;
    } exec_t;

    // one retired instruction as seen outside the core
    typedef struct packed {
        logic      valid;
        logic      wen;
        reg_addr_t rd;
        xword_t    wdata;
        xword_t    pc;
    } retire_t;

endpackage

`default_nettype wire

/* hdl/decode.sv */
// decode stage: format views, immediate build, control bundle and illegal flag
`timescale 1ns/100ps
`default_nettype none

`include "core_consts.svh"

module decode (
    input  wire logic [`INST_W-1:0] inst,
    output core_pkg::ctrl_t         ctrl,
    output core_pkg::reg_addr_t     rs1,
    output core_pkg::reg_addr_t     rs2
);
    import isa_pkg::*;
    import core_pkg::*;

    inst_u      iw;
    logic [6:0] opcode;
    xword_t     imm_i;
    xword_t     imm_b;
    xword_t     imm_u;
    xword_t     imm_j;

    assign iw     = inst;
    assign opcode = iw.r.opcode;
    assign rs1    = iw.r.rs1;
    assign rs2    = iw.r.rs2;

    // sign extended immediates, one per format
    assign imm_i = {{(`XLEN-12){iw.i.imm[11]}}, iw.i.imm};
    assign imm_b = {{(`XLEN-13){iw.s.imm_hi[6]}}, iw.s.imm_hi[6], iw.s.imm_lo[0],
                    iw.s.imm_hi[5:0], iw.s.imm_lo[4:1], 1'b0};
    assign imm_u = {{(`XLEN-32){iw.u.imm[19]}}, iw.u.imm, 12'b0};
    assign imm_j = {{(`XLEN-21){iw.u.imm[19]}}, iw.u.imm[19], iw.u.imm[7:0],
                    iw.u.imm[8], iw.u.imm[18:9], 1'b0};

    always_comb begin
        ctrl.alu_op    = ALU_ADD;
        ctrl.src_a     = SRC_A_RS1;
        ctrl.src_b     = SRC_B_IMM;
        ctrl.wb_sel    = WB_ALU;
        ctrl.pc_sel    = PC_SEQ;
        ctrl.br_funct3 = iw.r.funct3;
        ctrl.reg_wen   = 1'b0;
        ctrl.rd        = iw.r.rd;
        ctrl.imm       = imm_i;
        ctrl.illegal   = 1'b0;

        case (opcode)
            OPC_LUI: begin
                ctrl.imm     = imm_u;
                ctrl.alu_op  = ALU_PASS_B;
                ctrl.reg_wen = 1'b1;
            end
            OPC_AUIPC: begin
                ctrl.imm     = imm_u;
                ctrl.src_a   = SRC_A_PC;        // pc + imm
                ctrl.reg_wen = 1'b1;
            end
            OPC_JAL: begin
                ctrl.imm     = imm_j;
                ctrl.wb_sel  = WB_PC4;          // link
                ctrl.pc_sel  = PC_JAL;
                ctrl.reg_wen = 1'b1;
            end
            OPC_JALR: begin
                ctrl.wb_sel  = WB_PC4;
                ctrl.pc_sel  = PC_JALR;
                ctrl.reg_wen = 1'b1;
                ctrl.illegal = (iw.i.funct3 != 3'b000);
            end
            OPC_BRANCH: begin
                ctrl.imm    = imm_b;
                ctrl.pc_sel = PC_BRANCH;
                ctrl.illegal = !(iw.s.funct3 inside {F3_BEQ, F3_BNE, F3_BLT, F3_BGE});
            end
            OPC_OP_IMM: begin
                ctrl.reg_wen = 1'b1;
                case (iw.i.funct3)
                    F3_ADD_SUB: ctrl.alu_op = ALU_ADD;
                    F3_SLT:     ctrl.alu_op = ALU_SLT;
                    F3_XOR:     ctrl.alu_op = ALU_XOR;
                    F3_OR:      ctrl.alu_op = ALU_OR;
                    F3_AND:     ctrl.alu_op = ALU_AND;
                    default:    ctrl.illegal = 1'b1;   // shifts, SLTIU
                endcase
            end
            OPC_OP: begin
                ctrl.src_b   = SRC_B_RS2;
                ctrl.reg_wen = 1'b1;
                case (iw.r.funct3)
                    F3_ADD_SUB: ctrl.alu_op = iw.r.funct7[5] ? ALU_SUB : ALU_ADD;
                    F3_SLT:     ctrl.alu_op = ALU_SLT;
                    F3_XOR:     ctrl.alu_op = ALU_XOR;
                    F3_OR:      ctrl.alu_op = ALU_OR;
                    F3_AND:     ctrl.alu_op = ALU_AND;
                    default:    ctrl.illegal = 1'b1;
                endcase
                // only SUB may set a funct7 bit
                if (iw.r.funct7 != F7_BASE &&
                    !(iw.r.funct7 == F7_ALT && iw.r.funct3 == F3_ADD_SUB)) begin
                    ctrl.illegal = 1'b1;
                end
            end
            default: ctrl.illegal = 1'b1;
        endcase

        // illegal words retire as a no-op
        if (ctrl.illegal) begin
            ctrl.reg_wen = 1'b0;
            ctrl.pc_sel  = PC_SEQ;
        end
    end

endmodule

`default_nettype wire

/* hdl/reg_file.sv */
// integer register file: two async read ports, one write port, x0 held at zero
`timescale 1ns/100ps
`default_nettype none

`include "core_consts.svh"

module reg_file (
    input  wire                clk,
    input  wire                arst_n,
    input  wire                wen,
    input  wire  [`REG_AW-1:0] waddr,
    input  wire  [`REG_AW-1:0] raddr1,
    input  wire  [`REG_AW-1:0] raddr2,
    input  wire  [`XLEN-1:0]   wdata,
    output logic [`XLEN-1:0]   rdata1,
    output logic [`XLEN-1:0]   rdata2
);

    logic [`XLEN-1:0] regs [`REG_NUM];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin   // x0 never written
            regs[waddr] <= wdata;
        end
    end

    // x0 stays zero since reset cleared it and writes skip it
    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

    a_x0_reads_zero: assert property (@(posedge clk) disable iff (!arst_n)
        (raddr1 == '0) |-> (rdata1 == '0))
        else $error("x0 read back nonzero: %h", rdata1);

endmodule

`default_nettype wire

/* hdl/execute.sv */
// execute stage: operand muxes, ALU and branch compare
`timescale 1ns/100ps
`default_nettype none

module execute (
    input  wire core_pkg::ctrl_t ctrl,
    input  wire core_pkg::xword_t pc,
    input  wire core_pkg::xword_t rs1_data,
    input  wire core_pkg::xword_t rs2_data,
    output core_pkg::exec_t      ex
);
    import core_pkg::*;

    xword_t op_a;
    xword_t op_b;
    xword_t alu_res;
    logic   br_eq;
    logic   br_lt;
    logic   br_cond;

    assign op_a = (ctrl.src_a == SRC_A_PC)  ? pc       : rs1_data;
    assign op_b = (ctrl.src_b == SRC_B_IMM) ? ctrl.imm : rs2_data;

    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD:    alu_res = op_a + op_b;
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_SLT:    alu_res = xword_t'($signed(op_a) < $signed(op_b));
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_OR:     alu_res = op_a | op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = '0;
        endcase
    end

    // branch compare always works on the register values
    assign br_eq = (rs1_data == rs2_data);
    assign br_lt = ($signed(rs1_data) < $signed(rs2_data));

    // funct3[2] picks lt over eq, funct3[0] negates (BNE, BGE)
    assign br_cond = (ctrl.br_funct3[2] ? br_lt : br_eq) ^ ctrl.br_funct3[0];

    always_comb begin
        ex.alu_res      = alu_res;
        ex.branch_taken = (ctrl.pc_sel == PC_BRANCH) && br_cond;
    end

endmodule

`default_nettype wire

/* hdl/result.sv */
// result stage: PC register, run flag, next-PC select and retire record
`timescale 1ns/100ps
`default_nettype none

`include "core_consts.svh"

module result (
    input  wire                   clk,
    input  wire                   arst_n,
    input  wire core_pkg::ctrl_t  ctrl,
    input  wire core_pkg::exec_t  ex,
    input  wire core_pkg::xword_t rs1_data,
    output core_pkg::xword_t      pc,
    output core_pkg::retire_t     retire
);
    import core_pkg::*;

    xword_t pc_seq;
    xword_t pc_rel;
    xword_t jalr_sum;
    xword_t next_pc;
    logic   run;

    assign pc_seq   = pc + xword_t'(4);
    assign pc_rel   = pc + ctrl.imm;            // JAL and taken branch
    assign jalr_sum = rs1_data + ctrl.imm;

    always_comb begin
        case (ctrl.pc_sel)
            PC_SEQ:    next_pc = pc_seq;
            PC_BRANCH: next_pc = ex.branch_taken ? pc_rel : pc_seq;
            PC_JAL:    next_pc = pc_rel;
            PC_JALR:   next_pc = {jalr_sum[`XLEN-1:1], 1'b0};
            default:   next_pc = pc_seq;
        endcase
    end

    // pc holds at the reset vector until the first edge sets run
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc  <= `RESET_PC;
            run <= 1'b0;
        end else begin
            run <= 1'b1;
            if (run) begin
                pc <= next_pc;
            end
        end
    end

    always_comb begin
        retire.valid = run;
        retire.wen   = run && ctrl.reg_wen;
        retire.rd    = ctrl.rd;
        retire.wdata = (ctrl.wb_sel == WB_PC4) ? pc_seq : ex.alu_res;   // link or ALU
        retire.pc    = pc;
    end

    a_pc_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        (run && ctrl.pc_sel inside {PC_JAL, PC_BRANCH} && pc[1:0] == 2'b00)
        |=> (pc[1:0] == 2'b00))
        else $error("misaligned pc after jump or branch: %h", pc);

endmodule

`default_nettype wire

/* hdl/rv_core_top.sv */
// core top: decode, register file, execute and result stages wired together
`timescale 1ns/100ps
`default_nettype none

`include "core_consts.svh"

module rv_core_top (
    input  wire                    clk,
    input  wire                    arst_n,
    input  wire  [`INST_W-1:0]     inst,
    output core_pkg::xword_t       pc,
    output core_pkg::retire_t      retire,
    output logic                   illegal_inst
);
    import core_pkg::*;

    ctrl_t     ctrl;
    reg_addr_t rs1;
    reg_addr_t rs2;
    xword_t    rs1_data;
    xword_t    rs2_data;
    exec_t     ex;

    assign illegal_inst = ctrl.illegal;

    decode u_decode_0 (
        .inst       ( inst          ),
        .ctrl       ( ctrl          ),
        .rs1        ( rs1           ),
        .rs2        ( rs2           )
    );

    // write port fed back from the retire record
    reg_file u_reg_file_0 (
        .clk        ( clk           ),
        .arst_n     ( arst_n        ),
        .wen        ( retire.wen    ),
        .waddr      ( retire.rd     ),
        .raddr1     ( rs1           ),
        .raddr2     ( rs2           ),
        .wdata      ( retire.wdata  ),
        .rdata1     ( rs1_data      ),
        .rdata2     ( rs2_data      )
    );

    execute u_execute_0 (
        .ctrl       ( ctrl          ),
        .pc         ( pc            ),
        .rs1_data   ( rs1_data      ),
        .rs2_data   ( rs2_data      ),
        .ex         ( ex            )
    );

    result u_result_0 (
        .clk        ( clk           ),
        .arst_n     ( arst_n        ),
        .ctrl       ( ctrl          ),
        .ex         ( ex            ),
        .rs1_data   ( rs1_data      ),     // JALR base
        .pc         ( pc            ),
        .retire     ( retire        )
    );

endmodule

`default_nettype wire

/* dv/tb_ref_model.svh */
// reference model of the RV64I subset: shadow registers, model pc and one-instruction step
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

xword_t shadow_regs [`REG_NUM];     // architectural registers as the model sees them
xword_t model_pc;                   // pc of the next instruction to retire

// ALU result for OP and OP-IMM funct3, flags unsupported funct3
function automatic xword_t alu_ref(
    input  logic [2:0] f3,
    input  xword_t     x,
    input  xword_t     y,
    output logic       bad
);
    xword_t res;

    bad = 1'b0;
    res = '0;
    case (f3)
        F3_ADD_SUB: res = x + y;
        F3_SLT:     res = {{(`XLEN-1){1'b0}}, ($signed(x) < $signed(y))};
        F3_XOR:     res = x ^ y;
        F3_OR:      res = x | y;
        F3_AND:     res = x & y;
        default:    bad = 1'b1;         // shifts and SLTIU
    endcase
    return res;
endfunction

// one instruction against the given state, returns the expected retire record
function automatic retire_t ref_exec(
    input  logic [`INST_W-1:0] word,
    input  xword_t             cur_pc,
    input  xword_t             regs [`REG_NUM],
    output xword_t             npc,
    output logic               bad
);
    retire_t    rec;
    logic [6:0] opc;
    logic [2:0] f3;
    logic [6:0] f7;
    xword_t     a;
    xword_t     b;
    xword_t     imm_i;
    xword_t     imm_b;
    xword_t     imm_u;
    xword_t     imm_j;
    logic       take;

    opc   = word[6:0];
    f3    = word[14:12];
    f7    = word[31:25];
    a     = regs[word[19:15]];
    b     = regs[word[24:20]];
    imm_i = {{(`XLEN-12){word[31]}}, word[31:20]};
    imm_b = {{(`XLEN-13){word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
    imm_u = {{(`XLEN-32){word[31]}}, word[31:12], 12'h000};
    imm_j = {{(`XLEN-21){word[31]}}, word[31], word[19:12], word[20], word[30:21], 1'b0};
    take  = 1'b0;
    bad   = 1'b0;
    npc   = cur_pc + xword_t'(4);

    rec.valid = 1'b1;
    rec.wen   = 1'b0;
    rec.rd    = word[11:7];
    rec.wdata = '0;
    rec.pc    = cur_pc;

    case (opc)
        OPC_LUI: begin
            rec.wen   = 1'b1;
            rec.wdata = imm_u;
        end
        OPC_AUIPC: begin
            rec.wen   = 1'b1;
            rec.wdata = cur_pc + imm_u;
        end
        OPC_JAL: begin
            rec.wen   = 1'b1;
            rec.wdata = cur_pc + xword_t'(4);
            npc       = cur_pc + imm_j;
        end
        OPC_JALR: begin
            bad       = (f3 != 3'b000);
            rec.wen   = 1'b1;
            rec.wdata = cur_pc + xword_t'(4);
            npc       = (a + imm_i) & ~xword_t'(1);   // target bit 0 dropped
        end
        OPC_BRANCH: begin
            case (f3)
                F3_BEQ:  take = (a == b);
                F3_BNE:  take = (a != b);
                F3_BLT:  take = ($signed(a) < $signed(b));
                F3_BGE:  take = ($signed(a) >= $signed(b));
                default: bad = 1'b1;
            endcase
            if (take) begin
                npc = cur_pc + imm_b;
            end
        end
        OPC_OP_IMM: begin
            rec.wen   = 1'b1;
            rec.wdata = alu_ref(f3, a, imm_i, bad);
        end
        OPC_OP: begin
            rec.wen = 1'b1;
            if (f7 == F7_ALT && f3 == F3_ADD_SUB) begin
                rec.wdata = a - b;
            end else begin
                rec.wdata = alu_ref(f3, a, b, bad);
                if (f7 != F7_BASE) begin
                    bad = 1'b1;                     // reserved funct7
                end
            end
        end
        default: bad = 1'b1;
    endcase

    // illegal words behave as a plain pc + 4 step
    if (bad) begin
        rec.wen = 1'b0;
        npc     = cur_pc + xword_t'(4);
    end
    return rec;
endfunction

`endif

/* dv/tb_core.sv */
// testbench for rv_core_top: clock, reset, random instruction stream, compare process, timeout
`timescale 1ns/100ps
`default_nettype none

`include "core_consts.svh"

module tb_core;
    import isa_pkg::*;
    import core_pkg::*;

    localparam int CLK_HALF       = 50;                         // 100 ns period
    localparam int RESET_CYCLES   = 5;
    localparam int N_INST         = 2000;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + N_INST + 95;  // margin over the run

    logic               clk;
    logic               arst_n;
    logic [`INST_W-1:0] inst;
    xword_t             pc;
    retire_t            retire;
    logic               illegal_inst;

    integer seed;
    int     cycle_cnt = 0;

`include "tb_ref_model.svh"

    rv_core_top i_rv_core_top (
        .clk          ( clk          ),
        .arst_n       ( arst_n       ),
        .inst         ( inst         ),
        .pc           ( pc           ),
        .retire       ( retire       ),
        .illegal_inst ( illegal_inst )
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_HALF) clk = ~clk;
    end

    task automatic stop_on_mismatch(input string msg);
        $display("ERR %0t ns: %s", $time, msg);
        $display("TEST FAIL");
        $fatal(1, "run stopped at first mismatch");
    endtask

    task automatic check_pc(input xword_t got, input xword_t exp, input string what);
        if (got !== exp) begin
            stop_on_mismatch($sformatf("%s got %h expected %h", what, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stop_on_mismatch($sformatf("%s got %b expected %b", what, got, exp));
        end
    endtask

    task automatic check_retire(input retire_t got, input retire_t exp);
        check_flag(got.valid, exp.valid, "retire.valid");
        check_flag(got.wen, exp.wen, "retire.wen");
        check_pc(got.pc, exp.pc, "retire.pc");
        if (exp.wen) begin                                  // rd and wdata only matter on a write
            if (got.rd !== exp.rd) begin
                stop_on_mismatch($sformatf("retire.rd got %0d expected %0d", got.rd, exp.rd));
            end
            check_pc(got.wdata, exp.wdata, "retire.wdata");
        end
    endtask

    function automatic logic [2:0] pick_alu_f3(input int unsigned k);
        case (k % 5)
            0:       return F3_ADD_SUB;
            1:       return F3_SLT;
            2:       return F3_XOR;
            3:       return F3_OR;
            default: return F3_AND;
        endcase
    endfunction

    function automatic logic [2:0] pick_br_f3(input int unsigned k);
        case (k % 4)
            0:       return F3_BEQ;
            1:       return F3_BNE;
            2:       return F3_BLT;
            default: return F3_BGE;
        endcase
    endfunction

    // weighted mix of subset encodings, about 5 percent illegal words
    function automatic logic [`INST_W-1:0] draw_inst();
        logic [31:0] rnd;
        logic [31:0] aux;
        int unsigned pick;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] word;

        rnd  = $random(seed);
        aux  = $random(seed);
        pick = aux[15:0] % 100;
        word = rnd;
        if (pick < 5) begin
            case (aux[18:16])
                3'd0: word = {rnd[31:15], rnd[14:13], 1'b1, rnd[11:7], OPC_JALR};  // bad funct3
                3'd1: word = {rnd[31:15], rnd[14], 1'b1, rnd[12:7], OPC_BRANCH};  // unsigned
                3'd2: word = {rnd[31:15], rnd[14], 2'b01, rnd[11:7], OPC_OP_IMM}; // shifts
                3'd3: word = {1'b1, rnd[30:7], OPC_OP};                           // reserved f7
                default: begin
                    if (word[6:0] inside {OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR,
                                          OPC_BRANCH, OPC_OP_IMM, OPC_OP}) begin
                        word[6:0] = 7'b0000011;             // load, not supported
                    end
                end
            endcase
        end else if (pick < 13) begin
            word = {rnd[31:12], rnd[11:7], OPC_LUI};
        end else if (pick < 21) begin
            word = {rnd[31:12], rnd[11:7], OPC_AUIPC};
        end else if (pick < 28) begin
            word = {rnd[31:22], 1'b0, rnd[20:12], rnd[11:7], OPC_JAL};   // imm[1] kept 0
        end else if (pick < 35) begin
            word = {rnd[31:20], rnd[19:15], 3'b000, rnd[11:7], OPC_JALR};
        end else if (pick < 55) begin
            f3   = pick_br_f3(aux[31:16]);
            word = {rnd[31:25], rnd[24:20], rnd[19:15], f3, rnd[11:9], 1'b0, rnd[7],
                    OPC_BRANCH};
        end else if (pick < 80) begin
            f3   = pick_alu_f3(aux[31:16]);
            word = {rnd[31:20], rnd[19:15], f3, rnd[11:7], OPC_OP_IMM};
        end else begin
            f3   = pick_alu_f3(aux[31:16]);
            f7   = (f3 == F3_ADD_SUB && rnd[0]) ? F7_ALT : F7_BASE;
            word = {f7, rnd[24:20], rnd[19:15], f3, rnd[11:7], OPC_OP};
        end
        return word;
    endfunction

    // reset, then one new instruction on every falling edge
    initial begin
        seed   = 32'h3fa5;
        arst_n = 1'b0;
        inst   = '0;
        for (int n = 0; n < RESET_CYCLES; n++) begin
            @(negedge clk);
            check_pc(pc, `RESET_PC, "pc in reset");
            check_flag(retire.valid, 1'b0, "retire.valid in reset");
            check_flag(retire.wen, 1'b0, "retire.wen in reset");
        end
        arst_n = 1'b1;
        inst   = draw_inst();
        forever begin
            @(negedge clk);
            inst = draw_inst();
        end
    end

    // compare process: sample before the edge, check and step the model at the edge
    initial begin
        logic [`INST_W-1:0] cur_inst;
        retire_t            got_ret;
        retire_t            exp_ret;
        xword_t             got_pc;
        xword_t             exp_npc;
        logic               got_ill;
        logic               exp_ill;

        for (int r = 0; r < `REG_NUM; r++) begin
            shadow_regs[r] = '0;
        end
        model_pc = `RESET_PC;
        wait (arst_n === 1'b1);
        @(posedge clk);                                     // run flag sets here
        for (int n = 0; n < N_INST; n++) begin
            @(negedge clk);
            #(CLK_HALF - 10);
            cur_inst = inst;
            got_ret  = retire;
            got_pc   = pc;
            got_ill  = illegal_inst;
            exp_ret  = ref_exec(cur_inst, model_pc, shadow_regs, exp_npc, exp_ill);
            @(posedge clk);
            check_pc(got_pc, model_pc, "pc");
            check_retire(got_ret, exp_ret);
            check_flag(got_ill, exp_ill, "illegal_inst");
            if (exp_ret.wen && exp_ret.rd != '0) begin
                shadow_regs[exp_ret.rd] = exp_ret.wdata;
            end
            model_pc = exp_npc;
        end
        @(negedge clk);
        check_pc(pc, model_pc, "pc after last retire");
        $display("TEST PASS");
        $finish;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("simulation timed out after %0d cycles before it finished", cycle_cnt);
            $display("TEST FAIL");
            $fatal(1, "timeout");
        end
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+hdl
+incdir+dv
hdl/isa_pkg.sv
hdl/core_pkg.sv
hdl/decode.sv
hdl/reg_file.sv
hdl/execute.sv
hdl/result.sv
hdl/rv_core_top.sv
dv/tb_core.sv

/* run_sim.sh */
#!/bin/sh
# Build the core testbench with Verilator and run it.
# The run passes only when the simulation prints the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/100ps \
    --top-module tb_core -f verilog.f \
    && ./obj_dir/Vtb_core | grep -F "TEST PASS" \
    || { echo "simulation did not pass"; exit 1; }

exit 0
